// ==== hdl/mem_read_pkg.sv ====
/*
 * memory read stage shared definitions
 * widths, operand typedefs, size and stack codes, dcache states, size_bytes()
 */
package mem_read_pkg;

    localparam int DADDRW    = 32;                       // data memory address width
    localparam int DDATAW    = 64;                       // data memory word width
    localparam int ADT_DEPTH = 4;                        // dependency table entries
    localparam int ADT_PTRW  = $clog2(ADT_DEPTH);        // head/tail pointer
    localparam int ADT_CNTW  = $clog2(ADT_DEPTH + 1);    // 0..ADT_DEPTH

    typedef logic [DADDRW-1:0] addr_t;
    typedef logic [DDATAW-1:0] data_t;     // operand value or memory word
    typedef logic [2:0]        size_t;     // operand size code
    typedef logic [2:0]        reg_t;      // register number
    typedef logic [1:0]        stack_op_t;
    typedef logic [31:0]       pc_t;
    typedef logic [15:0]       opcode_t;

    // size codes, 6 and 7 count as none
    localparam size_t SIZE_NONE = 3'd0;
    localparam size_t SIZE_8    = 3'd1;
    localparam size_t SIZE_16   = 3'd2;
    localparam size_t SIZE_32   = 3'd3;
    localparam size_t SIZE_48   = 3'd4;
    localparam size_t SIZE_64   = 3'd5;

    localparam stack_op_t STACK_PUSH = 2'b01;   // other codes are not a push

    typedef enum logic [2:0] {IDLE, REQ, WAIT, DONE, DRAIN} dcache_state_e;

    // byte count of an operand size code
    function automatic logic [3:0] size_bytes(size_t size);
        case (size)
            SIZE_NONE: return 4'd0;
            SIZE_8:    return 4'd1;
            SIZE_16:   return 4'd2;
            SIZE_32:   return 4'd4;
            SIZE_48:   return 4'd6;
            SIZE_64:   return 4'd8;
            default:   return 4'd0;   // unused codes
        endcase
    endfunction

endpackage

// ==== hdl/dcache_if.sv ====
/*
 * stage control to dcache interface handshake
 * master drives the read, slave reports progress and data
 */
`timescale 1ns/1ps

interface dcache_if (
    input logic clk,
    input logic rst
);

    logic                start;     // level, read wanted and not halted
    mem_read_pkg::addr_t address;   // latched by the slave on start
    logic                consume;   // instruction taken downstream
    logic                busy;      // request or response outstanding
    logic                done;      // data captured and held
    mem_read_pkg::data_t data;

    // control side, clk/rst only for its checks
    modport master (
        input  clk, rst, busy, done, data,
        output start, address, consume
    );

    modport slave (
        input  start, address, consume,
        output busy, done, data
    );

endinterface

// ==== hdl/dep_if.sv ====
/*
 * stage control to address dependency table
 * push of destination addresses and two overlap compares
 */
`timescale 1ns/1ps

interface dep_if;

    logic                push;           // accepted instr with address dest
    mem_read_pkg::addr_t push_address;
    mem_read_pkg::size_t size;           // shared by push and both compares
    mem_read_pkg::addr_t cmp0_address;   // operand a effective address
    mem_read_pkg::addr_t cmp1_address;   // op1 low word
    logic                cmp0_hit;
    logic                cmp1_hit;

    modport ctrl (
        output push, push_address, size, cmp0_address, cmp1_address,
        input  cmp0_hit, cmp1_hit
    );

    // table side
    modport tbl (
        input  push, push_address, size, cmp0_address, cmp1_address,
        output cmp0_hit, cmp1_hit
    );

endinterface

// ==== hdl/memory_read_ctrl.sv ====
/*
 * memory read stage control
 * operand select, stack push override, read data masking, halt, valid/ready join
 */
`timescale 1ns/1ps

module memory_read_ctrl (
    input  logic                    a_valid,
    output logic                    a_ready,
    input  mem_read_pkg::size_t     a_size,
    input  mem_read_pkg::data_t     a_op0,
    input  mem_read_pkg::data_t     a_op1,
    input  mem_read_pkg::reg_t      a_op0_reg,
    input  logic                    a_op0_is_address,
    input  logic                    a_op0_is_reg,
    input  logic                    a_op1_is_address,
    input  mem_read_pkg::stack_op_t a_stack_op,
    input  mem_read_pkg::addr_t     a_stack_address,
    input  mem_read_pkg::pc_t       a_pc,
    input  mem_read_pkg::opcode_t   a_opcode,
    output logic                    e_valid,
    input  logic                    e_ready,
    output mem_read_pkg::size_t     e_size,
    output mem_read_pkg::data_t     e_op_a,
    output mem_read_pkg::data_t     e_op_b,
    output mem_read_pkg::reg_t      e_op_a_reg,
    output mem_read_pkg::addr_t     e_op_a_address,
    output logic                    e_op_a_is_address,
    output logic                    e_op_a_is_reg,
    output mem_read_pkg::addr_t     e_op_b_address,
    output logic                    e_op_b_is_address,
    output mem_read_pkg::addr_t     e_stack_ptr,
    output mem_read_pkg::stack_op_t e_stack_op,
    output mem_read_pkg::pc_t       e_pc,
    output mem_read_pkg::opcode_t   e_opcode,
    dcache_if.master                dc,
    dep_if.ctrl                     dep
);

    // zero-extend memory word to operand size
    function automatic mem_read_pkg::data_t mask_to_size(mem_read_pkg::data_t d,
                                                         mem_read_pkg::size_t size);
        case (size)
            mem_read_pkg::SIZE_8:  return {56'h0, d[7:0]};
            mem_read_pkg::SIZE_16: return {48'h0, d[15:0]};
            mem_read_pkg::SIZE_32: return {32'h0, d[31:0]};
            mem_read_pkg::SIZE_48: return {16'h0, d[47:0]};
            mem_read_pkg::SIZE_64: return d;
            default:               return '0;   // none and unused codes
        endcase
    endfunction

    logic                stack_push;
    logic                op_a_is_address;
    mem_read_pkg::addr_t op_a_address;
    logic                read_needed;
    logic                read_ok;
    logic                halt;
    mem_read_pkg::data_t read_data;

    // push forces stack address in as destination
    assign stack_push      = (a_stack_op == mem_read_pkg::STACK_PUSH);
    assign op_a_address    = stack_push ? a_stack_address : a_op0[mem_read_pkg::DADDRW-1:0];
    assign op_a_is_address = a_op0_is_address | stack_push;

    // dependency table
    assign dep.push         = e_valid & e_ready & op_a_is_address;   // record on accept
    assign dep.push_address = op_a_address;
    assign dep.size         = a_size;
    assign dep.cmp0_address = op_a_address;
    assign dep.cmp1_address = a_op1[mem_read_pkg::DADDRW-1:0];

    assign halt = (dep.cmp0_hit & op_a_is_address) | (dep.cmp1_hit & a_op1_is_address);

    // only real operand addresses read memory, not the push slot
    assign read_needed = a_op0_is_address | a_op1_is_address;
    assign read_ok     = ~read_needed | dc.done;

    assign dc.start   = a_valid & read_needed & ~halt;
    assign dc.address = a_op0_is_address ? a_op0[mem_read_pkg::DADDRW-1:0]
                                         : a_op1[mem_read_pkg::DADDRW-1:0];
    assign dc.consume = e_valid & e_ready;

    // no pipe register, valid/ready go straight through
    assign e_valid = a_valid & ~halt & read_ok;
    assign a_ready = ~halt & read_ok & e_ready;

    assign read_data = mask_to_size(dc.data, a_size);
    assign e_op_a    = a_op0_is_address ? read_data : a_op0;
    assign e_op_b    = a_op1_is_address ? read_data : a_op1;

    assign e_size            = a_size;
    assign e_op_a_reg        = a_op0_reg;
    assign e_op_a_address    = op_a_address;
    assign e_op_a_is_address = op_a_is_address;
    assign e_op_a_is_reg     = a_op0_is_reg;
    assign e_op_b_address    = a_op1[mem_read_pkg::DADDRW-1:0];
    assign e_op_b_is_address = a_op1_is_address;
    assign e_stack_ptr       = a_stack_address;
    assign e_stack_op        = a_stack_op;
    assign e_pc              = a_pc;
    assign e_opcode          = a_opcode;

    // an issued read is never caught by a later table entry,
    // so e_valid in DONE cannot come up halted
    a_issued_not_halted: assert property (
        @(posedge dc.clk) disable iff (dc.rst)
        (dc.busy || dc.done) |-> !halt
    );

endmodule

// ==== hdl/dcache_interface.sv ====
/*
 * dcache interface FSM
 * issues one memory read, captures the data, holds it until consumed
 */
`timescale 1ns/1ps

module dcache_interface (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    dcache_if.slave             dc,
    output logic                rmem_valid,
    input  logic                rmem_ready,
    output mem_read_pkg::addr_t rmem_address,
    input  logic                rmem_dp_valid,
    output logic                rmem_dp_ready,
    input  mem_read_pkg::data_t rmem_dp_read_data
);

    mem_read_pkg::dcache_state_e state;
    mem_read_pkg::dcache_state_e state_nxt;
    mem_read_pkg::addr_t         addr_q;   // request address
    mem_read_pkg::data_t         data_q;   // captured response

    always_comb begin
        state_nxt = state;
        case (state)
            mem_read_pkg::IDLE: begin
                if (dc.start && !flush)
                    state_nxt = mem_read_pkg::REQ;
            end
            mem_read_pkg::REQ: begin
                if (rmem_ready)   // accepted, a response is now owed
                    state_nxt = flush ? mem_read_pkg::DRAIN : mem_read_pkg::WAIT;
                else if (flush)
                    state_nxt = mem_read_pkg::IDLE;
            end
            mem_read_pkg::WAIT: begin
                if (rmem_dp_valid)
                    state_nxt = flush ? mem_read_pkg::IDLE : mem_read_pkg::DONE;
                else if (flush)
                    state_nxt = mem_read_pkg::DRAIN;
            end
            mem_read_pkg::DONE: begin
                if (dc.consume || flush)   // hold under back-pressure
                    state_nxt = mem_read_pkg::IDLE;
            end
            mem_read_pkg::DRAIN: begin
                if (rmem_dp_valid)   // response thrown away
                    state_nxt = mem_read_pkg::IDLE;
            end
            default: state_nxt = mem_read_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= mem_read_pkg::IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (state == mem_read_pkg::IDLE && dc.start)
            addr_q <= dc.address;
        if (state == mem_read_pkg::WAIT && rmem_dp_valid)
            data_q <= rmem_dp_read_data;
    end

    assign rmem_valid    = (state == mem_read_pkg::REQ);
    assign rmem_address  = addr_q;
    assign rmem_dp_ready = (state == mem_read_pkg::WAIT) || (state == mem_read_pkg::DRAIN);

    assign dc.busy = (state == mem_read_pkg::REQ) || (state == mem_read_pkg::WAIT);
    assign dc.done = (state == mem_read_pkg::DONE);
    assign dc.data = data_q;

    // request address held until the memory takes it
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        rmem_valid && !rmem_ready |=> $stable(rmem_address)
    );

    // one read in flight, a response only comes while one is owed
    a_one_in_flight: assert property (
        @(posedge clk) disable iff (rst)
        rmem_dp_valid |-> rmem_dp_ready
    );

endmodule

// ==== hdl/address_dependency_table.sv ====
/*
 * address dependency table
 * circular store-address buffer, oldest-first pop, flush, two overlap compares
 */
`timescale 1ns/1ps

module address_dependency_table (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic pop,   // write-back retired a memory write
    dep_if.tbl   dep
);

    logic [mem_read_pkg::ADT_DEPTH-1:0] ent_valid;
    mem_read_pkg::addr_t                ent_addr [mem_read_pkg::ADT_DEPTH];
    mem_read_pkg::size_t                ent_size [mem_read_pkg::ADT_DEPTH];
    logic [mem_read_pkg::ADT_PTRW-1:0]  head;    // oldest entry
    logic [mem_read_pkg::ADT_PTRW-1:0]  tail;    // next free slot
    logic [mem_read_pkg::ADT_CNTW-1:0]  count;

    // byte ranges [a, a+na) and [b, b+nb) share a byte
    function automatic logic overlap(mem_read_pkg::addr_t a, mem_read_pkg::size_t a_size,
                                     mem_read_pkg::addr_t b, mem_read_pkg::size_t b_size);
        logic [3:0]                    a_len;
        logic [3:0]                    b_len;
        logic [mem_read_pkg::DADDRW:0] a_end;   // one extra bit, no wrap
        logic [mem_read_pkg::DADDRW:0] b_end;
        a_len = mem_read_pkg::size_bytes(a_size);
        b_len = mem_read_pkg::size_bytes(b_size);
        a_end = {1'b0, a} + a_len;
        b_end = {1'b0, b} + b_len;
        return (a_len != 0) && (b_len != 0) && ({1'b0, a} < b_end) && ({1'b0, b} < a_end);
    endfunction

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ent_valid <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            if (pop) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (dep.push) begin   // after pop, so push wins on a shared slot
                ent_valid[tail] <= 1'b1;
                tail            <= tail + 1'b1;
            end
            case ({dep.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none, or both
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (dep.push) begin
            ent_addr[tail] <= dep.push_address;
            ent_size[tail] <= dep.size;
        end
    end

    always_comb begin
        dep.cmp0_hit = 1'b0;
        dep.cmp1_hit = 1'b0;
        for (int i = 0; i < mem_read_pkg::ADT_DEPTH; i++) begin
            if (ent_valid[i] && overlap(ent_addr[i], ent_size[i], dep.cmp0_address, dep.size))
                dep.cmp0_hit = 1'b1;
            if (ent_valid[i] && overlap(ent_addr[i], ent_size[i], dep.cmp1_address, dep.size))
                dep.cmp1_hit = 1'b1;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst || flush)
        dep.push |-> count != mem_read_pkg::ADT_DEPTH
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst || flush)
        pop |-> count != 0
    );

endmodule

// ==== hdl/memory_read_top.sv ====
/*
 * memory read stage top level
 * control, dcache interface and dependency table joined by two interfaces
 */
`timescale 1ns/1ps

module memory_read_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    wb_valid,
    input  logic                    wb_ready,
    input  logic                    wb_to_memory,
    input  logic                    a_valid,
    output logic                    a_ready,
    input  mem_read_pkg::size_t     a_size,
    input  mem_read_pkg::data_t     a_op0,
    input  mem_read_pkg::data_t     a_op1,
    input  mem_read_pkg::reg_t      a_op0_reg,
    input  logic                    a_op0_is_address,
    input  logic                    a_op0_is_reg,
    input  logic                    a_op1_is_address,
    input  mem_read_pkg::stack_op_t a_stack_op,
    input  mem_read_pkg::addr_t     a_stack_address,
    input  mem_read_pkg::pc_t       a_pc,
    input  mem_read_pkg::opcode_t   a_opcode,
    output logic                    e_valid,
    input  logic                    e_ready,
    output mem_read_pkg::size_t     e_size,
    output mem_read_pkg::data_t     e_op_a,
    output mem_read_pkg::data_t     e_op_b,
    output mem_read_pkg::reg_t      e_op_a_reg,
    output mem_read_pkg::addr_t     e_op_a_address,
    output logic                    e_op_a_is_address,
    output logic                    e_op_a_is_reg,
    output mem_read_pkg::addr_t     e_op_b_address,
    output logic                    e_op_b_is_address,
    output mem_read_pkg::addr_t     e_stack_ptr,
    output mem_read_pkg::stack_op_t e_stack_op,
    output mem_read_pkg::pc_t       e_pc,
    output mem_read_pkg::opcode_t   e_opcode,
    output logic                    rmem_valid,
    input  logic                    rmem_ready,
    output mem_read_pkg::addr_t     rmem_address,
    input  logic                    rmem_dp_valid,
    output logic                    rmem_dp_ready,
    input  mem_read_pkg::data_t     rmem_dp_read_data
);

    logic wb_pop;   // retire of a memory write frees oldest entry

    assign wb_pop = wb_valid & wb_ready & wb_to_memory;

    dcache_if u_dc_if (.clk(clk), .rst(rst));
    dep_if    u_dep_if ();

    memory_read_ctrl u_ctrl (
        .a_valid, .a_ready, .a_size, .a_op0, .a_op1, .a_op0_reg,
        .a_op0_is_address, .a_op0_is_reg, .a_op1_is_address,
        .a_stack_op, .a_stack_address, .a_pc, .a_opcode,
        .e_valid, .e_ready, .e_size, .e_op_a, .e_op_b, .e_op_a_reg,
        .e_op_a_address, .e_op_a_is_address, .e_op_a_is_reg,
        .e_op_b_address, .e_op_b_is_address, .e_stack_ptr, .e_stack_op,
        .e_pc, .e_opcode,
        .dc  (u_dc_if.master),
        .dep (u_dep_if.ctrl)
    );

    dcache_interface u_dcache (
        .clk, .rst, .flush,
        .dc  (u_dc_if.slave),
        .rmem_valid, .rmem_ready, .rmem_address,
        .rmem_dp_valid, .rmem_dp_ready, .rmem_dp_read_data
    );

    address_dependency_table u_adt (
        .clk, .rst, .flush,
        .pop (wb_pop),
        .dep (u_dep_if.tbl)
    );

endmodule

// ==== test/tb_rmem_model.sv ====
/*
 * data memory responder for the testbench
 * random accept delay, read data built from the request address
 */
`timescale 1ns/1ps

module tb_rmem_model (
    input  logic                clk,
    input  logic                rst,
    input  logic                rmem_valid,
    output logic                rmem_ready,
    input  mem_read_pkg::addr_t rmem_address,
    output logic                rmem_dp_valid,
    input  logic                rmem_dp_ready,
    output mem_read_pkg::data_t rmem_dp_read_data,
    output int unsigned         req_count,      // accepted requests so far
    output mem_read_pkg::addr_t last_address    // address of the latest accept
);

    initial begin
        int unsigned delay;
        rmem_ready        = 1'b0;
        rmem_dp_valid     = 1'b0;
        rmem_dp_read_data = '0;
        req_count         = 0;
        last_address      = '0;
        void'($urandom(12));   // fixed seed, delays repeat run to run
        forever begin
            @(negedge clk);
            if (!rst && rmem_valid) begin
                delay = $urandom % 4;   // 0..3 cycles before ready
                repeat (delay) @(negedge clk);
                rmem_ready   = 1'b1;
                last_address = rmem_address;   // held stable by the DUT
                req_count++;
                @(negedge clk);
                rmem_ready = 1'b0;
                // response 1..3 cycles after the accept
                delay = 1 + $urandom % 3;
                repeat (delay - 1) @(negedge clk);
                rmem_dp_valid     = 1'b1;
                rmem_dp_read_data = {~last_address, last_address};
                @(negedge clk);   // taken at the posedge, dp_ready high in WAIT
                rmem_dp_valid     = 1'b0;
                rmem_dp_read_data = '0;
            end
        end
    end

endmodule

// ==== test/tb_memory_read_top.sv ====
/*
 * testbench for the memory read stage
 * clock, reset, directed tests, compare tasks, cycle timeout
 */
`timescale 1ns/1ps

module tb_memory_read_top;

    localparam int MAX_TXNS       = 60;
    localparam int MAX_TXN_CYCLES = 20;
    localparam int TIMEOUT_CYCLES = MAX_TXNS * MAX_TXN_CYCLES * 5 / 2;   // 3000, with margin

    logic                    clk;
    logic                    rst;
    logic                    flush;
    logic                    wb_valid;
    logic                    wb_ready;
    logic                    wb_to_memory;
    logic                    a_valid;
    logic                    a_ready;
    mem_read_pkg::size_t     a_size;
    mem_read_pkg::data_t     a_op0;
    mem_read_pkg::data_t     a_op1;
    mem_read_pkg::reg_t      a_op0_reg;
    logic                    a_op0_is_address;
    logic                    a_op0_is_reg;
    logic                    a_op1_is_address;
    mem_read_pkg::stack_op_t a_stack_op;
    mem_read_pkg::addr_t     a_stack_address;
    mem_read_pkg::pc_t       a_pc;
    mem_read_pkg::opcode_t   a_opcode;
    logic                    e_valid;
    logic                    e_ready;
    mem_read_pkg::size_t     e_size;
    mem_read_pkg::data_t     e_op_a;
    mem_read_pkg::data_t     e_op_b;
    mem_read_pkg::reg_t      e_op_a_reg;
    mem_read_pkg::addr_t     e_op_a_address;
    logic                    e_op_a_is_address;
    logic                    e_op_a_is_reg;
    mem_read_pkg::addr_t     e_op_b_address;
    logic                    e_op_b_is_address;
    mem_read_pkg::addr_t     e_stack_ptr;
    mem_read_pkg::stack_op_t e_stack_op;
    mem_read_pkg::pc_t       e_pc;
    mem_read_pkg::opcode_t   e_opcode;
    logic                    rmem_valid;
    logic                    rmem_ready;
    mem_read_pkg::addr_t     rmem_address;
    logic                    rmem_dp_valid;
    logic                    rmem_dp_ready;
    mem_read_pkg::data_t     rmem_dp_read_data;
    int unsigned             req_count;      // from the memory model
    mem_read_pkg::addr_t     last_address;
    int                      cycles;
    int                      instr_count;    // seeds pc, opcode, reg fields

    memory_read_top u_dut (.*);

    tb_rmem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // expected memory word, inverted address on top
    function automatic mem_read_pkg::data_t mem_word(mem_read_pkg::addr_t a);
        return {~a, a};
    endfunction

    // the operand that is not read, a plain register value
    function automatic mem_read_pkg::data_t reg_operand(mem_read_pkg::addr_t a);
        return {32'h600d_0000, a ^ 32'h5555_aaaa};
    endfunction

    // zero-extend to the operand size: 1, 2, 4, 6, 8 bytes, else nothing
    function automatic mem_read_pkg::data_t masked(mem_read_pkg::data_t d,
                                                   mem_read_pkg::size_t size);
        int nbytes;
        case (size)
            3'd1:    nbytes = 1;
            3'd2:    nbytes = 2;
            3'd3:    nbytes = 4;
            3'd4:    nbytes = 6;
            3'd5:    nbytes = 8;
            default: nbytes = 0;
        endcase
        if (nbytes == 8)
            return d;
        return d & ((64'd1 << (8 * nbytes)) - 64'd1);
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input mem_read_pkg::data_t expected,
                              input mem_read_pkg::data_t actual);
        if (actual !== expected)
            fail_stop($sformatf("Fail %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    task automatic check_addr(input string name, input mem_read_pkg::addr_t expected,
                              input mem_read_pkg::addr_t actual);
        if (actual !== expected)
            fail_stop($sformatf("Fail %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            fail_stop($sformatf("Fail %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    // drive one instruction, call at a falling edge
    task automatic set_instr(input mem_read_pkg::size_t size, input mem_read_pkg::data_t op0,
                             input mem_read_pkg::data_t op1, input logic op0_addr,
                             input logic op1_addr, input mem_read_pkg::stack_op_t stack_op,
                             input mem_read_pkg::addr_t stack_addr);
        a_size           = size;
        a_op0            = op0;
        a_op1            = op1;
        a_op0_is_address = op0_addr;
        a_op0_is_reg     = !op0_addr;
        a_op1_is_address = op1_addr;
        a_op0_reg        = mem_read_pkg::reg_t'(instr_count);
        a_stack_op       = stack_op;
        a_stack_address  = stack_addr;
        a_pc             = 32'h0040_0000 + 4 * instr_count;
        a_opcode         = mem_read_pkg::opcode_t'(16'h8b00 + instr_count);
        a_valid          = 1'b1;
        instr_count++;
    endtask

    // sample just after the falling edge, outputs settled
    task automatic wait_e_valid();
        #1;
        while (!e_valid) begin
            @(negedge clk);
            #1;
        end
    endtask

    // write-back retires the oldest memory write
    task automatic retire_write();
        wb_valid     = 1'b1;
        wb_ready     = 1'b1;
        wb_to_memory = 1'b1;
        @(negedge clk);
        wb_valid     = 1'b0;
        wb_ready     = 1'b0;
        wb_to_memory = 1'b0;
    endtask

    task automatic expect_blocked(input int n);
        repeat (n) begin
            #1;
            check_bit("a_ready", 1'b0, a_ready);
            check_bit("e_valid", 1'b0, e_valid);
            check_bit("rmem_valid", 1'b0, rmem_valid);
            @(negedge clk);
        end
    endtask

    task automatic present_read(input logic via_op1, input mem_read_pkg::size_t size,
                                input mem_read_pkg::addr_t addr);
        @(negedge clk);
        if (via_op1)
            set_instr(size, reg_operand(addr), {32'hbeef_0000, addr}, 1'b0, 1'b1, 2'b00, '0);
        else
            set_instr(size, {32'hcafe_0000, addr}, reg_operand(addr), 1'b1, 1'b0, 2'b00, '0);
    endtask

    // wait for the read, check it, hand it to execute
    task automatic complete_read(input logic via_op1, input mem_read_pkg::size_t size,
                                 input mem_read_pkg::addr_t addr, input int unsigned reqs);
        wait_e_valid();
        check_bit("a_ready", 1'b1, a_ready);
        check_addr("rmem_address", addr, last_address);
        if (via_op1) begin
            check_data("e_op_b", masked(mem_word(addr), size), e_op_b);
            check_data("e_op_a", reg_operand(addr), e_op_a);
        end else begin
            check_data("e_op_a", masked(mem_word(addr), size), e_op_a);
            check_data("e_op_b", reg_operand(addr), e_op_b);
        end
        check_data("rmem request count", 64'd1, mem_read_pkg::data_t'(req_count - reqs));
        @(negedge clk);   // consumed at the posedge before
        a_valid = 1'b0;
        if (!via_op1)
            retire_write();   // op0 address went into the table
    endtask

    task automatic test_reg_operands();
        int unsigned reqs;
        reqs = req_count;
        @(negedge clk);
        set_instr(3'd3, 64'h1122_3344_5566_7788, 64'h99aa_bbcc_ddee_ff00,
                  1'b0, 1'b0, 2'b10, 32'h0000_8000);
        #1;   // same cycle, no register in the path
        check_bit("e_valid", 1'b1, e_valid);
        check_bit("a_ready", 1'b1, a_ready);
        check_data("e_op_a", 64'h1122_3344_5566_7788, e_op_a);
        check_data("e_op_b", 64'h99aa_bbcc_ddee_ff00, e_op_b);
        check_data("e_size", 64'd3, mem_read_pkg::data_t'(e_size));
        check_data("e_stack_op", 64'd2, mem_read_pkg::data_t'(e_stack_op));
        check_data("e_op_a_reg", mem_read_pkg::data_t'(a_op0_reg),
                   mem_read_pkg::data_t'(e_op_a_reg));
        check_data("e_opcode", mem_read_pkg::data_t'(a_opcode), mem_read_pkg::data_t'(e_opcode));
        check_addr("e_pc", a_pc, e_pc);
        check_addr("e_op_b_address", 32'hddee_ff00, e_op_b_address);
        check_addr("e_stack_ptr", 32'h0000_8000, e_stack_ptr);
        check_bit("e_op_a_is_address", 1'b0, e_op_a_is_address);
        check_bit("e_op_b_is_address", 1'b0, e_op_b_is_address);
        check_bit("e_op_a_is_reg", 1'b1, e_op_a_is_reg);
        @(negedge clk);
        e_ready = 1'b0;   // a_ready follows e_ready
        #1;
        check_bit("a_ready", 1'b0, a_ready);
        check_bit("e_valid", 1'b1, e_valid);
        check_bit("rmem_valid", 1'b0, rmem_valid);   // no read started at the edge
        @(negedge clk);
        a_valid = 1'b0;
        e_ready = 1'b1;
        check_data("rmem request count", 64'd0, mem_read_pkg::data_t'(req_count - reqs));
    endtask

    task automatic test_op0_reads();
        int unsigned reqs;
        for (int s = 0; s < 8; s++) begin
            reqs = req_count;
            present_read(1'b0, mem_read_pkg::size_t'(s), 32'h0000_1000 + 32'h44 * s);
            complete_read(1'b0, mem_read_pkg::size_t'(s), 32'h0000_1000 + 32'h44 * s, reqs);
        end
    endtask

    task automatic test_backpressure();
        int unsigned         reqs;
        mem_read_pkg::addr_t addr;
        reqs    = req_count;
        addr    = 32'h0000_2468;
        e_ready = 1'b0;
        present_read(1'b1, 3'd5, addr);
        wait_e_valid();
        check_data("e_op_b", mem_word(addr), e_op_b);
        repeat (5) begin   // DONE holds the data
            @(negedge clk);
            #1;
            check_bit("e_valid", 1'b1, e_valid);
            check_bit("a_ready", 1'b0, a_ready);
            check_data("e_op_b", mem_word(addr), e_op_b);
        end
        @(negedge clk);
        e_ready = 1'b1;
        #1;
        check_bit("a_ready", 1'b1, a_ready);
        @(negedge clk);
        a_valid = 1'b0;
        check_data("rmem request count", 64'd1, mem_read_pkg::data_t'(req_count - reqs));
    endtask

    task automatic test_stack_push();
        int unsigned reqs;
        reqs = req_count;
        @(negedge clk);
        set_instr(3'd3, 64'h00aa, 64'h00bb, 1'b0, 1'b0, mem_read_pkg::STACK_PUSH, 32'h0000_7ff0);
        #1;
        check_bit("e_valid", 1'b1, e_valid);
        check_addr("e_op_a_address", 32'h0000_7ff0, e_op_a_address);
        check_bit("e_op_a_is_address", 1'b1, e_op_a_is_address);
        check_data("e_op_a", 64'h00aa, e_op_a);   // register value kept
        @(negedge clk);
        check_bit("rmem_valid", 1'b0, rmem_valid);   // push slot starts no read
        a_valid = 1'b0;
        check_data("rmem request count", 64'd0, mem_read_pkg::data_t'(req_count - reqs));
        retire_write();
    endtask

    task automatic test_dependency();
        int unsigned reqs;
        @(negedge clk);
        set_instr(3'd3, 64'h0, 64'h0, 1'b0, 1'b0, mem_read_pkg::STACK_PUSH, 32'h0000_1000);
        #1;
        check_bit("e_valid", 1'b1, e_valid);
        @(negedge clk);   // entry 0x1000..0x1003 recorded
        a_valid = 1'b0;
        reqs    = req_count;
        present_read(1'b0, 3'd2, 32'h0000_1002);
        expect_blocked(4);
        a_valid = 1'b0;
        present_read(1'b1, 3'd3, 32'h0000_2000);   // no overlap, goes through
        complete_read(1'b1, 3'd3, 32'h0000_2000, reqs);
        reqs = req_count;
        present_read(1'b0, 3'd2, 32'h0000_1002);
        expect_blocked(3);
        retire_write();   // frees 0x1000, read may start
        complete_read(1'b0, 3'd2, 32'h0000_1002, reqs);
    endtask

    task automatic test_flush();
        int unsigned reqs;
        @(negedge clk);
        set_instr(3'd5, 64'h0, 64'h0, 1'b0, 1'b0, mem_read_pkg::STACK_PUSH, 32'h0000_3000);
        #1;
        check_bit("e_valid", 1'b1, e_valid);
        @(negedge clk);
        a_valid = 1'b0;
        reqs    = req_count;
        present_read(1'b1, 3'd3, 32'h0000_3004);   // inside 0x3000..0x3007
        expect_blocked(3);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        complete_read(1'b1, 3'd3, 32'h0000_3004, reqs);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        fail_stop($sformatf("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        instr_count      = 0;
        rst              = 1'b1;
        flush            = 1'b0;
        wb_valid         = 1'b0;
        wb_ready         = 1'b0;
        wb_to_memory     = 1'b0;
        a_valid          = 1'b0;
        a_size           = '0;
        a_op0            = '0;
        a_op1            = '0;
        a_op0_reg        = '0;
        a_op0_is_address = 1'b0;
        a_op0_is_reg     = 1'b0;
        a_op1_is_address = 1'b0;
        a_stack_op       = '0;
        a_stack_address  = '0;
        a_pc             = '0;
        a_opcode         = '0;
        e_ready          = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        #1;
        check_bit("rmem_valid", 1'b0, rmem_valid);
        check_bit("rmem_dp_ready", 1'b0, rmem_dp_ready);
        check_bit("e_valid", 1'b0, e_valid);
        test_reg_operands();
        test_op0_reads();
        test_backpressure();
        test_stack_push();
        test_dependency();
        test_flush();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/mem_read_pkg.sv
hdl/dcache_if.sv
hdl/dep_if.sv
hdl/memory_read_ctrl.sv
hdl/dcache_interface.sv
hdl/address_dependency_table.sv
hdl/memory_read_top.sv
test/tb_rmem_model.sv
test/tb_memory_read_top.sv

// ==== Bender.yml ====
package:
  name: memory_read_stage

sources:
  - files:
      - hdl/mem_read_pkg.sv
      - hdl/dcache_if.sv
      - hdl/dep_if.sv
      - hdl/memory_read_ctrl.sv
      - hdl/dcache_interface.sv
      - hdl/address_dependency_table.sv
      - hdl/memory_read_top.sv
  - target: test
    files:
      - test/tb_rmem_model.sv
      - test/tb_memory_read_top.sv
